// File: src/aip_settings.svh
`ifndef AIP_SETTINGS_SVH
`define AIP_SETTINGS_SVH

// Host and memory word width
`define AIP_DATA_WIDTH 32

// Pointer bits taken from the host data word
`define AIP_PTR_WIDTH 16

// Address bits of each input memory
`define AIP_MEMIN_DEPTH_LOG 5

// Address bits of the output memory
`define AIP_MEMOUT_DEPTH_LOG 6

`define AIP_IP_ID 32'h1000500A

`endif

// File: src/aipPkg.sv
`default_nettype none

package aipPkg;

  // Host configuration codes
  typedef enum logic [4:0] {
    MemIn0Data  = 5'd0,
    MemIn0Ptr   = 5'd1,
    MemIn1Data  = 5'd2,
    MemIn1Ptr   = 5'd3,
    MemOutData  = 5'd4,
    MemOutPtr   = 5'd5,
    ConfRegData = 5'd6,
    ConfRegPtr  = 5'd7,
    Status      = 5'd30,
    Id          = 5'd31
  } aipConfigE;

  // Sources of the host read data
  typedef enum logic [1:0] {
    SelMemOut = 2'd0,
    SelZero   = 2'd1,
    SelStatus = 2'd2,
    SelId     = 2'd3
  } readSelE;

endpackage

`default_nettype wire

// File: src/memPkg.sv
`default_nettype none

`include "aip_settings.svh"

package memPkg;

  typedef logic [`AIP_DATA_WIDTH-1:0] wordT;
  typedef logic [`AIP_PTR_WIDTH-1:0] ptrT;

  // Status word layout
  localparam int StatBusyBit  = 0;
  localparam int StatDoneBit  = 8;
  localparam int StatIntEnBit = 16;

endpackage

`default_nettype wire

// File: src/aipAccessIf.sv
`default_nettype none

interface aipAccessIf;

  logic [1:0] memInWrEn;     // One per input memory
  memPkg::ptrT memInWrPtr0;
  memPkg::ptrT memInWrPtr1;
  memPkg::ptrT memOutRdPtr;
  logic confWrEn;

  modport ctrl (
    output memInWrEn,
    output memInWrPtr0,
    output memInWrPtr1,
    output memOutRdPtr,
    output confWrEn
  );

  modport store (
    input memInWrEn,
    input memInWrPtr0,
    input memInWrPtr1,
    input memOutRdPtr,
    input confWrEn
  );

endinterface

`default_nettype wire

// File: src/aipDualPortRam.sv
`default_nettype none

module aipDualPortRam #(
  parameter int addrBits = 5
) (
  input  logic                clk,
  input  logic                wrEn_i,
  input  logic [addrBits-1:0] wrAddr_i,
  input  memPkg::wordT        wrData_i,
  input  logic [addrBits-1:0] rdAddr_i,
  output memPkg::wordT        rdData_o
);

  memPkg::wordT mem [2**addrBits];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  // Read is combinational
  assign rdData_o = mem[rdAddr_i];

endmodule

`default_nettype wire

// File: src/aipCtrl.sv
`default_nettype none

module aipCtrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              en_i,
  input  logic              writeAIP_i,
  input  logic              readAIP_i,
  input  aipPkg::aipConfigE configAIP_i,
  input  memPkg::ptrT       ptrIn_i,
  aipAccessIf.ctrl          acc,
  output logic              setStatus_o,
  output aipPkg::readSelE   readSel_o
);

  memPkg::ptrT memIn0Ptr;
  memPkg::ptrT memIn1Ptr;
  memPkg::ptrT memOutPtr;
  logic        confPtr;   // Single config register entry

  logic wrMemIn0;
  logic wrMemIn1;
  logic wrConf;
  logic rdMemOut;

  assign wrMemIn0 = writeAIP_i && (configAIP_i == aipPkg::MemIn0Data);
  assign wrMemIn1 = writeAIP_i && (configAIP_i == aipPkg::MemIn1Data);
  assign wrConf   = writeAIP_i && (configAIP_i == aipPkg::ConfRegData);
  assign rdMemOut = readAIP_i && (configAIP_i == aipPkg::MemOutData);

  // Pointer preset takes priority over auto-increment
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memIn0Ptr <= '0;
      memIn1Ptr <= '0;
      memOutPtr <= '0;
      confPtr   <= 1'b0;
    end else if (en_i) begin
      if (writeAIP_i && configAIP_i == aipPkg::MemIn0Ptr) begin
        memIn0Ptr <= ptrIn_i;
      end else if (wrMemIn0) begin
        memIn0Ptr <= memIn0Ptr + 1'b1;
      end

      if (writeAIP_i && configAIP_i == aipPkg::MemIn1Ptr) begin
        memIn1Ptr <= ptrIn_i;
      end else if (wrMemIn1) begin
        memIn1Ptr <= memIn1Ptr + 1'b1;
      end

      if (writeAIP_i && configAIP_i == aipPkg::MemOutPtr) begin
        memOutPtr <= ptrIn_i;
      end else if (rdMemOut) begin
        memOutPtr <= memOutPtr + 1'b1;
      end

      if (writeAIP_i && configAIP_i == aipPkg::ConfRegPtr) begin
        confPtr <= ptrIn_i[0];
      end else if (wrConf) begin
        confPtr <= 1'b0;   // Wraps after the only entry
      end
    end
  end

  assign acc.memInWrEn   = {wrMemIn1, wrMemIn0};
  assign acc.memInWrPtr0 = memIn0Ptr;
  assign acc.memInWrPtr1 = memIn1Ptr;
  assign acc.memOutRdPtr = memOutPtr;
  assign acc.confWrEn    = wrConf && !confPtr;

  assign setStatus_o = writeAIP_i && (configAIP_i == aipPkg::Status);

  always_comb begin
    case (configAIP_i)
      aipPkg::MemOutData: readSel_o = aipPkg::SelMemOut;
      aipPkg::Status:     readSel_o = aipPkg::SelStatus;
      aipPkg::Id:         readSel_o = aipPkg::SelId;
      default:            readSel_o = aipPkg::SelZero;
    endcase
  end

endmodule

`default_nettype wire

// File: src/aipStorage.sv
`default_nettype none

`include "aip_settings.svh"

module aipStorage #(
  parameter int memInBits  = `AIP_MEMIN_DEPTH_LOG,
  parameter int memOutBits = `AIP_MEMOUT_DEPTH_LOG
) (
  input  logic         clk,
  input  logic         rst,
  aipAccessIf.store    acc,
  input  memPkg::wordT wrData_i,
  input  memPkg::ptrT  rdAddrMemIn0_i,
  input  memPkg::ptrT  rdAddrMemIn1_i,
  input  logic         wrEnMemOut_i,
  input  memPkg::ptrT  wrAddrMemOut_i,
  input  memPkg::wordT wrDataMemOut_i,
  output memPkg::wordT rdDataMemIn0_o,
  output memPkg::wordT rdDataMemIn1_o,
  output memPkg::wordT memOutData_o,
  output memPkg::wordT confReg_o
);

  // Host writes, core reads
  aipDualPortRam #(.addrBits(memInBits)) memIn0 (
    .clk      (clk),
    .wrEn_i   (acc.memInWrEn[0]),
    .wrAddr_i (acc.memInWrPtr0[memInBits-1:0]),
    .wrData_i (wrData_i),
    .rdAddr_i (rdAddrMemIn0_i[memInBits-1:0]),
    .rdData_o (rdDataMemIn0_o)
  );

  aipDualPortRam #(.addrBits(memInBits)) memIn1 (
    .clk      (clk),
    .wrEn_i   (acc.memInWrEn[1]),
    .wrAddr_i (acc.memInWrPtr1[memInBits-1:0]),
    .wrData_i (wrData_i),
    .rdAddr_i (rdAddrMemIn1_i[memInBits-1:0]),
    .rdData_o (rdDataMemIn1_o)
  );

  // Core writes, host reads at its pointer
  aipDualPortRam #(.addrBits(memOutBits)) memOut (
    .clk      (clk),
    .wrEn_i   (wrEnMemOut_i),
    .wrAddr_i (wrAddrMemOut_i[memOutBits-1:0]),
    .wrData_i (wrDataMemOut_i),
    .rdAddr_i (acc.memOutRdPtr[memOutBits-1:0]),
    .rdData_o (memOutData_o)
  );

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      confReg_o <= '0;
    end else if (acc.confWrEn) begin
      confReg_o <= wrData_i;
    end
  end

endmodule

`default_nettype wire

// File: src/aipStatusRead.sv
`default_nettype none

`include "aip_settings.svh"

module aipStatusRead (
  input  logic            clk,
  input  logic            rst,
  input  logic            setStatus_i,
  input  memPkg::wordT    wrData_i,
  input  logic            coreBusy_i,
  input  logic            coreDone_i,
  input  aipPkg::readSelE readSel_i,
  input  memPkg::wordT    memOutData_i,
  output memPkg::wordT    dataOut_o,
  output logic            intReq_o
);

  logic         doneQ;
  logic         doneRise;
  logic         donePend;
  logic         intEn;
  memPkg::wordT statusWord;

  assign doneRise = coreDone_i && !doneQ;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      doneQ    <= 1'b0;
      donePend <= 1'b0;
      intEn    <= 1'b0;
    end else begin
      doneQ <= coreDone_i;
      if (doneRise) begin
        donePend <= 1'b1;   // New done event wins over a clear
      end else if (setStatus_i && wrData_i[memPkg::StatDoneBit]) begin
        donePend <= 1'b0;
      end
      if (setStatus_i) begin
        intEn <= wrData_i[memPkg::StatIntEnBit];
      end
    end
  end

  assign intReq_o = donePend && intEn;

  always_comb begin
    statusWord = '0;
    statusWord[memPkg::StatBusyBit]  = coreBusy_i;
    statusWord[memPkg::StatDoneBit]  = donePend;
    statusWord[memPkg::StatIntEnBit] = intEn;
  end

  always_comb begin
    case (readSel_i)
      aipPkg::SelMemOut: dataOut_o = memOutData_i;
      aipPkg::SelStatus: dataOut_o = statusWord;
      aipPkg::SelId:     dataOut_o = `AIP_IP_ID;
      default:           dataOut_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/aipTop.sv
`default_nettype none

`include "aip_settings.svh"

module aipTop (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en_i,
  input  logic [`AIP_DATA_WIDTH-1:0] dataInAIP_i,
  output logic [`AIP_DATA_WIDTH-1:0] dataOutAIP_o,
  input  logic [4:0]                configAIP_i,
  input  logic                      readAIP_i,
  input  logic                      writeAIP_i,
  input  logic                      startAIP_i,
  output logic                      intAIP_o,
  input  logic [`AIP_PTR_WIDTH-1:0]  rdAddrMemIn0_i,
  input  logic [`AIP_PTR_WIDTH-1:0]  rdAddrMemIn1_i,
  output logic [`AIP_DATA_WIDTH-1:0] rdDataMemIn0_o,
  output logic [`AIP_DATA_WIDTH-1:0] rdDataMemIn1_o,
  input  logic                      wrEnMemOut_i,
  input  logic [`AIP_PTR_WIDTH-1:0]  wrAddrMemOut_i,
  input  logic [`AIP_DATA_WIDTH-1:0] wrDataMemOut_i,
  output logic [`AIP_DATA_WIDTH-1:0] rdDataConfigReg_o,
  input  logic                      statusBusy_i,
  input  logic                      coreDone_i,
  output logic                      startIPcore_o
);

  aipPkg::aipConfigE configCode;
  aipPkg::readSelE   readSel;
  logic              setStatus;
  memPkg::wordT      memOutData;

  assign configCode    = aipPkg::aipConfigE'(configAIP_i);
  assign startIPcore_o = startAIP_i;   // No latency to the core

  aipAccessIf accIf ();

  aipCtrl ctrl (
    .clk         (clk),
    .rst         (rst),
    .en_i        (en_i),
    .writeAIP_i  (writeAIP_i),
    .readAIP_i   (readAIP_i),
    .configAIP_i (configCode),
    .ptrIn_i     (dataInAIP_i[`AIP_PTR_WIDTH-1:0]),
    .acc         (accIf),
    .setStatus_o (setStatus),
    .readSel_o   (readSel)
  );

  aipStorage storage (
    .clk            (clk),
    .rst            (rst),
    .acc            (accIf),
    .wrData_i       (dataInAIP_i),
    .rdAddrMemIn0_i (rdAddrMemIn0_i),
    .rdAddrMemIn1_i (rdAddrMemIn1_i),
    .wrEnMemOut_i   (wrEnMemOut_i),
    .wrAddrMemOut_i (wrAddrMemOut_i),
    .wrDataMemOut_i (wrDataMemOut_i),
    .rdDataMemIn0_o (rdDataMemIn0_o),
    .rdDataMemIn1_o (rdDataMemIn1_o),
    .memOutData_o   (memOutData),
    .confReg_o      (rdDataConfigReg_o)
  );

  aipStatusRead statusRead (
    .clk          (clk),
    .rst          (rst),
    .setStatus_i  (setStatus),
    .wrData_i     (dataInAIP_i),
    .coreBusy_i   (statusBusy_i),
    .coreDone_i   (coreDone_i),
    .readSel_i    (readSel),
    .memOutData_i (memOutData),
    .dataOut_o    (dataOutAIP_o),
    .intReq_o     (intAIP_o)
  );

endmodule

`default_nettype wire

// File: testbench/aipChecker.sv
`default_nettype none

module aipChecker (
  input  logic        clk,
  input  logic        chkValid_i,
  input  logic [2:0]  chkSig_i,
  input  logic [31:0] chkExp_i,
  input  logic        waitReq_i,
  input  logic [31:0] dataOutAIP_i,
  input  logic [31:0] rdDataMemIn0_i,
  input  logic [31:0] rdDataMemIn1_i,
  input  logic [31:0] rdDataConfigReg_i,
  input  logic        intAIP_i,
  input  logic        startIPcore_i,
  output logic        waitDone_o,
  output int          checks_o,
  output int          errors_o,
  output int          timeouts_o
);

  localparam int IntTimeout = 20;   // Cycles allowed for the interrupt

  int          checkCnt = 0;
  int          errorCnt = 0;
  int          timeoutCnt = 0;
  logic        waiting = 1'b0;
  logic        waitDone = 1'b0;
  logic        waitExp = 1'b0;
  int          waitCycles = 0;
  logic [31:0] seen;
  string       name;

  assign waitDone_o = waitDone;
  assign checks_o   = checkCnt;
  assign errors_o   = errorCnt;
  assign timeouts_o = timeoutCnt;

  // Sampled mid cycle, well after the drive point
  always @(negedge clk) begin
    if (chkValid_i) begin
      case (chkSig_i)
        3'd1: begin
          seen = rdDataMemIn0_i;
          name = "rdDataMemIn0_o";
        end
        3'd2: begin
          seen = rdDataMemIn1_i;
          name = "rdDataMemIn1_o";
        end
        3'd3: begin
          seen = rdDataConfigReg_i;
          name = "rdDataConfigReg_o";
        end
        3'd4: begin
          seen = {31'd0, intAIP_i};
          name = "intAIP_o";
        end
        3'd5: begin
          seen = {31'd0, startIPcore_i};
          name = "startIPcore_o";
        end
        default: begin
          seen = dataOutAIP_i;
          name = "dataOutAIP_o";
        end
      endcase
      checkCnt++;
      if (seen !== chkExp_i) begin
        errorCnt++;
        $display("error %s got %h expected %h", name, seen, chkExp_i);
      end
    end
    if (waitReq_i && !waiting) begin
      waiting = 1'b1;
      waitDone = 1'b0;
      waitExp = chkExp_i[0];
      waitCycles = 0;
    end
    if (waiting) begin
      if (intAIP_i === waitExp) begin
        waiting = 1'b0;
        waitDone = 1'b1;
        checkCnt++;
      end else if (waitCycles == IntTimeout) begin
        $display("timeout: intAIP_o did not reach %0b within %0d cycles", waitExp, IntTimeout);
        timeoutCnt++;
        waiting = 1'b0;
        waitDone = 1'b1;
      end else begin
        waitCycles++;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/aipTb.sv
`default_nettype none

module aipTb;

  typedef enum int {
    OpHostWr, OpHostRd, OpCoreWr, OpCoreRd0, OpCoreRd1,
    OpSet, OpDone, OpStart, OpConfChk, OpIntChk, OpIntWait
  } opE;

  typedef struct {
    opE                op;
    aipPkg::aipConfigE code;
    logic [31:0]       data;
    logic [15:0]       addr;
    logic [31:0]       exp;
    logic              cmp;
  } rowT;

  // Watched port codes, same numbering as the checker
  localparam logic [2:0] SigData  = 3'd0;
  localparam logic [2:0] SigMem0  = 3'd1;
  localparam logic [2:0] SigMem1  = 3'd2;
  localparam logic [2:0] SigConf  = 3'd3;
  localparam logic [2:0] SigInt   = 3'd4;
  localparam logic [2:0] SigStart = 3'd5;
  localparam int         WaitLimit = 40;   // Above the checker's own limit

  logic        clk = 1'b0;
  logic        rst;
  logic        en_i;
  logic [31:0] dataInAIP_i;
  logic [31:0] dataOutAIP_o;
  logic [4:0]  configAIP_i;
  logic        readAIP_i;
  logic        writeAIP_i;
  logic        startAIP_i;
  logic        intAIP_o;
  logic [15:0] rdAddrMemIn0_i;
  logic [15:0] rdAddrMemIn1_i;
  logic [31:0] rdDataMemIn0_o;
  logic [31:0] rdDataMemIn1_o;
  logic        wrEnMemOut_i;
  logic [15:0] wrAddrMemOut_i;
  logic [31:0] wrDataMemOut_i;
  logic [31:0] rdDataConfigReg_o;
  logic        statusBusy_i;
  logic        coreDone_i;
  logic        startIPcore_o;

  logic        chkValid;
  logic [2:0]  chkSig;
  logic [31:0] chkExp;
  logic        waitReq;
  logic        waitDone;
  int          checks;
  int          errors;
  int          timeouts;

  logic [31:0] lfsr = 32'h2fd2_ac82;
  rowT         rows [$];
  logic [31:0] words [16];
  logic        stuck;
  int          i;
  int          n;

  always #2 clk = ~clk;

  aipTop uut (.*);

  aipChecker chk (
    .clk               (clk),
    .chkValid_i        (chkValid),
    .chkSig_i          (chkSig),
    .chkExp_i          (chkExp),
    .waitReq_i         (waitReq),
    .dataOutAIP_i      (dataOutAIP_o),
    .rdDataMemIn0_i    (rdDataMemIn0_o),
    .rdDataMemIn1_i    (rdDataMemIn1_o),
    .rdDataConfigReg_i (rdDataConfigReg_o),
    .intAIP_i          (intAIP_o),
    .startIPcore_i     (startIPcore_o),
    .waitDone_o        (waitDone),
    .checks_o          (checks),
    .errors_o          (errors),
    .timeouts_o        (timeouts)
  );

  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] val;
    int          k;
    val = '0;
    for (k = 0; k < count; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic addRow(input opE op, input aipPkg::aipConfigE code, input logic [31:0] data,
                        input logic [15:0] addr, input logic [31:0] exp, input logic cmp);
    rowT r;
    r = '{op, code, data, addr, exp, cmp};
    rows.push_back(r);
  endtask

  task automatic buildRows();
    int          k;
    logic [31:0] busyB;
    logic [31:0] doneB;
    logic [31:0] intB;
    busyB = 32'd1 << memPkg::StatBusyBit;
    doneB = 32'd1 << memPkg::StatDoneBit;
    intB  = 32'd1 << memPkg::StatIntEnBit;
    addRow(OpHostRd, aipPkg::Id, '0, '0, 32'h1000500A, 1'b1);
    addRow(OpHostRd, aipPkg::aipConfigE'(5'd12), '0, '0, '0, 1'b1);   // Unused code
    // Input memories filled from preset pointers
    addRow(OpHostWr, aipPkg::MemIn0Ptr, 32'd3, '0, '0, 1'b0);
    for (k = 0; k < 4; k++) begin
      words[k] = takeBits(32);
      addRow(OpHostWr, aipPkg::MemIn0Data, words[k], '0, '0, 1'b0);
    end
    addRow(OpHostWr, aipPkg::MemIn1Ptr, 32'd20, '0, '0, 1'b0);
    for (k = 4; k < 8; k++) begin
      words[k] = takeBits(32);
      addRow(OpHostWr, aipPkg::MemIn1Data, words[k], '0, '0, 1'b0);
    end
    for (k = 0; k < 4; k++) begin
      addRow(OpCoreRd0, aipPkg::Id, '0, 16'(3 + k), words[k], 1'b1);
      addRow(OpCoreRd1, aipPkg::Id, '0, 16'(20 + k), words[k + 4], 1'b1);
    end
    // Output memory at addresses 40 to 44
    for (k = 8; k < 13; k++) begin
      words[k] = takeBits(32);
      addRow(OpCoreWr, aipPkg::Id, words[k], 16'(32 + k), '0, 1'b0);
    end
    addRow(OpHostWr, aipPkg::MemOutPtr, 32'd40, '0, '0, 1'b0);
    for (k = 8; k < 12; k++) begin
      addRow(OpHostRd, aipPkg::MemOutData, '0, '0, words[k], 1'b1);
    end
    addRow(OpSet, aipPkg::Id, 32'd0, '0, '0, 1'b0);   // en_i low
    addRow(OpHostRd, aipPkg::MemOutData, '0, '0, words[12], 1'b1);
    addRow(OpHostRd, aipPkg::MemOutData, '0, '0, words[12], 1'b1);
    addRow(OpSet, aipPkg::Id, 32'd1, '0, '0, 1'b0);
    addRow(OpHostRd, aipPkg::MemOutData, '0, '0, words[12], 1'b1);
    words[13] = takeBits(32);
    addRow(OpHostWr, aipPkg::ConfRegData, words[13], '0, '0, 1'b0);
    addRow(OpConfChk, aipPkg::Id, '0, '0, words[13], 1'b1);
    // Status, done and interrupt
    addRow(OpSet, aipPkg::Id, 32'd3, '0, '0, 1'b0);
    addRow(OpHostRd, aipPkg::Status, '0, '0, busyB, 1'b1);
    addRow(OpDone, aipPkg::Id, '0, '0, '0, 1'b0);
    addRow(OpHostRd, aipPkg::Status, '0, '0, busyB | doneB, 1'b1);
    addRow(OpIntChk, aipPkg::Id, '0, '0, 32'd0, 1'b1);
    addRow(OpSet, aipPkg::Id, 32'd1, '0, '0, 1'b0);
    addRow(OpHostWr, aipPkg::Status, intB, '0, '0, 1'b0);
    addRow(OpIntWait, aipPkg::Id, '0, '0, 32'd1, 1'b0);
    addRow(OpHostRd, aipPkg::Status, '0, '0, doneB | intB, 1'b1);
    addRow(OpHostWr, aipPkg::Status, doneB | intB, '0, '0, 1'b0);
    addRow(OpIntChk, aipPkg::Id, '0, '0, 32'd0, 1'b1);
    addRow(OpHostRd, aipPkg::Status, '0, '0, intB, 1'b1);
    addRow(OpStart, aipPkg::Id, 32'd1, '0, 32'd1, 1'b1);
    addRow(OpStart, aipPkg::Id, 32'd0, '0, 32'd0, 1'b1);
  endtask

  task automatic applyRow(input rowT r);
    writeAIP_i = 1'b0;
    readAIP_i = 1'b0;
    wrEnMemOut_i = 1'b0;
    coreDone_i = 1'b0;
    startAIP_i = 1'b0;
    waitReq = 1'b0;
    configAIP_i = r.code;
    dataInAIP_i = r.data;
    chkExp = r.exp;
    chkValid = r.cmp;
    case (r.op)
      OpHostWr: writeAIP_i = 1'b1;
      OpHostRd: begin
        readAIP_i = 1'b1;
        chkSig = SigData;
      end
      OpCoreWr: begin
        wrEnMemOut_i = 1'b1;
        wrAddrMemOut_i = r.addr;
        wrDataMemOut_i = r.data;
      end
      OpCoreRd0: begin
        rdAddrMemIn0_i = r.addr;
        chkSig = SigMem0;
      end
      OpCoreRd1: begin
        rdAddrMemIn1_i = r.addr;
        chkSig = SigMem1;
      end
      OpSet: begin
        en_i = r.data[0];
        statusBusy_i = r.data[1];
      end
      OpDone: coreDone_i = 1'b1;
      OpStart: begin
        startAIP_i = r.data[0];
        chkSig = SigStart;
      end
      OpConfChk: chkSig = SigConf;
      OpIntChk: chkSig = SigInt;
      default: waitReq = 1'b1;
    endcase
  endtask

  initial begin
    rst = 1'b0;
    en_i = 1'b1;
    dataInAIP_i = '0;
    configAIP_i = '0;
    readAIP_i = 1'b0;
    writeAIP_i = 1'b0;
    startAIP_i = 1'b0;
    rdAddrMemIn0_i = '0;
    rdAddrMemIn1_i = '0;
    wrEnMemOut_i = 1'b0;
    wrAddrMemOut_i = '0;
    wrDataMemOut_i = '0;
    statusBusy_i = 1'b0;
    coreDone_i = 1'b0;
    chkValid = 1'b0;
    chkSig = SigData;
    chkExp = '0;
    waitReq = 1'b0;
    stuck = 1'b0;
    buildRows();
    repeat (5) @(posedge clk);
    #1 rst = 1'b1;
    for (i = 0; i < rows.size() && !stuck; i++) begin
      @(posedge clk);
      #1;
      applyRow(rows[i]);
      if (rows[i].op == OpIntWait) begin
        @(posedge clk);
        #1;
        waitReq = 1'b0;
        n = 0;
        while (!waitDone && n < WaitLimit) begin
          @(posedge clk);
          n++;
        end
        if (!waitDone) begin
          $display("testbench gave up waiting for the interrupt check to finish");
          stuck = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
    chkValid = 1'b0;
    repeat (2) @(posedge clk);
    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && !stuck) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/aipPkg.sv
src/memPkg.sv
src/aipAccessIf.sv
src/aipDualPortRam.sv
src/aipCtrl.sv
src/aipStorage.sv
src/aipStatusRead.sv
src/aipTop.sv
testbench/aipChecker.sv
testbench/aipTb.sv

// File: run.sh
#!/bin/sh
# Build and run the aipTop testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module aipTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VaipTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0
